/* pce_input_top.f */
+incdir+.
pce_input_pkg.sv
multitap_scanner.sv
mouse_reader.sv
pad_nibble_select.sv
pce_input_top.sv
pce_input_checker.sv
pce_input_top_tb.sv

/* Makefile */
TOOL       = verilator
TOP        = pce_input_top_tb
RTL_TOP    = pce_input_top
FILELIST   = pce_input_top.f
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* pce_input_top_tb.sv */
/*
 * Testbench for pce_input_top. Rows run in order and keep the DUT state between them.
 * Each row settles for a fixed count of clk_sys cycles before joy_in is compared.
 */

`timescale 1ns/1ps

module pce_input_top_tb;

	import pce_input_pkg::*;

	localparam int MAX_SETTLE = 8;

	localparam input_cfg_t CFG_NONE  = 3'b000;
	localparam input_cfg_t CFG_TAP   = 3'b100;
	localparam input_cfg_t CFG_SIX   = 3'b010;
	localparam input_cfg_t CFG_MOUSE = 3'b001;

	// {clr, sel}
	localparam port_ctl_t CTL_IDLE = 2'b00;
	localparam port_ctl_t CTL_SEL  = 2'b01;
	localparam port_ctl_t CTL_CLR  = 2'b10;
	localparam port_ctl_t CTL_BOTH = 2'b11;

	// Pads 4 down to 0, different directions held on each
	localparam pad_set_t PADS_A = {12'hC33, 12'h0E8, 12'h964, 12'h5C2, 12'h3A1};
	localparam pad_set_t PADS_Z = '0;

	// stb toggled, dy 21, dx 03, right button down
	localparam mouse_pkt_t PKT_IDLE = '0;
	localparam mouse_pkt_t PKT_MOVE = {1'b1, 8'h21, 8'h03, 8'h02};

	typedef struct packed {
		input_cfg_t cfg;
		port_ctl_t  ctl;
		pad_set_t   pads;
		mouse_pkt_t pkt;
		logic [3:0] settle;
		nibble_t    exp_nib;
	} stim_row_t;

	logic       clk_sys;
	logic       reset;
	port_ctl_t  port_ctl;
	input_cfg_t cfg;
	pad_set_t   pads;
	mouse_pkt_t mouse_pkt;
	nibble_t    joy_in;
	logic       check_req;
	logic       report_req;
	int         row_num;
	nibble_t    exp_nib;
	int         error_count;
	logic       timed_out;
	stim_row_t  rows[$];

	always #20 clk_sys = ~clk_sys;

	pce_input_top pce_input_top_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.port_ctl  (port_ctl),
		.cfg       (cfg),
		.pads      (pads),
		.mouse_pkt (mouse_pkt),
		.joy_in    (joy_in)
	);

	pce_input_checker checker_i (
		.clk_sys     (clk_sys),
		.joy_in      (joy_in),
		.check_req   (check_req),
		.report_req  (report_req),
		.row_num     (row_num),
		.exp_nib     (exp_nib),
		.error_count (error_count)
	);

	function automatic void add_row(input input_cfg_t c, input port_ctl_t ctl,
			input pad_set_t p, input mouse_pkt_t k, input int settle, input nibble_t e);
		stim_row_t r;
		r = '{c, ctl, p, k, 4'(settle), e};
		rows.push_back(r);
	endfunction

	// Counts rising edges, expires past MAX_SETTLE
	task automatic wait_settle(input int settle, output logic expired);
		int n;
		n = 0;
		expired = 1'b0;
		while (n < settle && !expired) begin
			@(posedge clk_sys);
			n++;
			expired = (n >= MAX_SETTLE) && (n < settle);
		end
	endtask

	initial begin
		int idx;
		clk_sys    = 1'b0;
		reset      = 1'b1;
		port_ctl   = CTL_IDLE;
		cfg        = CFG_NONE;
		pads       = PADS_A;
		mouse_pkt  = PKT_IDLE;
		check_req  = 1'b0;
		report_req = 1'b0;
		row_num    = 0;
		exp_nib    = '0;
		timed_out  = 1'b0;
		idx        = 0;

		// Single pad, port stays 0 on sel
		add_row(CFG_NONE,  CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'h5);
		add_row(CFG_NONE,  CTL_SEL,  PADS_A, PKT_IDLE, 3, 4'hD);
		// clr high hides the pads
		add_row(CFG_NONE,  CTL_CLR,  PADS_A, PKT_IDLE, 3, 4'h0);
		add_row(CFG_NONE,  CTL_BOTH, PADS_Z, PKT_IDLE, 3, 4'h0);
		add_row(CFG_NONE,  CTL_IDLE, PADS_Z, PKT_IDLE, 3, 4'hF);
		// Multitap, each sel rise moves to the next pad
		add_row(CFG_TAP,   CTL_CLR,  PADS_A, PKT_IDLE, 3, 4'h0);
		add_row(CFG_TAP,   CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'h5);
		add_row(CFG_TAP,   CTL_SEL,  PADS_A, PKT_IDLE, 3, 4'hB);
		add_row(CFG_TAP,   CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'h3);
		add_row(CFG_TAP,   CTL_SEL,  PADS_A, PKT_IDLE, 3, 4'h7);
		add_row(CFG_TAP,   CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'h9);
		add_row(CFG_TAP,   CTL_SEL,  PADS_A, PKT_IDLE, 3, 4'hE);
		add_row(CFG_TAP,   CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'h1);
		add_row(CFG_TAP,   CTL_SEL,  PADS_A, PKT_IDLE, 4, 4'h9);
		add_row(CFG_TAP,   CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'hC);
		add_row(CFG_TAP,   CTL_SEL,  PADS_A, PKT_IDLE, 3, 4'hF);
		add_row(CFG_TAP,   CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'hF);
		// Six-button bank flips on each clr pulse
		add_row(CFG_SIX,   CTL_CLR,  PADS_A, PKT_IDLE, 3, 4'h0);
		add_row(CFG_SIX,   CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'hC);
		add_row(CFG_SIX,   CTL_SEL,  PADS_A, PKT_IDLE, 3, 4'h0);
		add_row(CFG_SIX,   CTL_CLR,  PADS_A, PKT_IDLE, 3, 4'h0);
		add_row(CFG_SIX,   CTL_IDLE, PADS_A, PKT_IDLE, 3, 4'h5);
		// Mouse, x = FD then y = 21, one nibble per clr pulse
		add_row(CFG_MOUSE, CTL_IDLE, PADS_A, PKT_MOVE, 3, 4'h6);
		add_row(CFG_MOUSE, CTL_CLR,  PADS_A, PKT_MOVE, 3, 4'h0);
		add_row(CFG_MOUSE, CTL_SEL,  PADS_A, PKT_MOVE, 3, 4'hF);
		add_row(CFG_MOUSE, CTL_IDLE, PADS_A, PKT_MOVE, 3, 4'h6);
		add_row(CFG_MOUSE, CTL_CLR,  PADS_A, PKT_MOVE, 3, 4'h0);
		add_row(CFG_MOUSE, CTL_SEL,  PADS_A, PKT_MOVE, 3, 4'hD);
		add_row(CFG_MOUSE, CTL_CLR,  PADS_A, PKT_MOVE, 3, 4'h0);
		add_row(CFG_MOUSE, CTL_SEL,  PADS_A, PKT_MOVE, 3, 4'h2);
		add_row(CFG_MOUSE, CTL_CLR,  PADS_A, PKT_MOVE, 3, 4'h0);
		add_row(CFG_MOUSE, CTL_SEL,  PADS_A, PKT_MOVE, 3, 4'h1);

		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		while (idx < rows.size() && !timed_out) begin
			@(negedge clk_sys);
			cfg       = rows[idx].cfg;
			port_ctl  = rows[idx].ctl;
			pads      = rows[idx].pads;
			mouse_pkt = rows[idx].pkt;
			wait_settle(int'(rows[idx].settle), timed_out);
			if (timed_out) begin
				$display("Row %0d did not settle within %0d cycles", idx, MAX_SETTLE);
			end else begin
				@(negedge clk_sys);
				row_num   = idx;
				exp_nib   = rows[idx].exp_nib;
				check_req = 1'b1;
				@(negedge clk_sys);
				check_req = 1'b0;
			end
			idx++;
		end

		report_req = 1'b1;
		@(negedge clk_sys);
		report_req = 1'b0;
		if (error_count == 0 && !timed_out) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* pce_input_checker.sv */
/*
 * Compares joy_in with the expected nibble of one stimulus row.
 * joy_in is read on the rising edge while check_req is high.
 */

`timescale 1ns/1ps

module pce_input_checker (
	input  logic                   clk_sys,
	input  pce_input_pkg::nibble_t joy_in,
	input  logic                   check_req,
	input  logic                   report_req,
	input  int                     row_num,
	input  pce_input_pkg::nibble_t exp_nib,
	output int                     error_count
);

	int fail_cnt = 0;
	int pass_cnt = 0;

	assign error_count = fail_cnt;

	always @(posedge clk_sys) begin
		if (check_req) begin
			if (joy_in !== exp_nib) begin
				fail_cnt = fail_cnt + 1;
				$display("Fail at %0d ns: row %0d joy_in %h, expected %h",
					$time, row_num, joy_in, exp_nib);
			end else begin
				pass_cnt = pass_cnt + 1;
				$display("Pass at %0d ns: row %0d joy_in %h", $time, row_num, joy_in);
			end
		end
		// Closing counts
		if (report_req) begin
			$display("Rows checked %0d, passed %0d, failed %0d",
				pass_cnt + fail_cnt, pass_cnt, fail_cnt);
		end
	end

endmodule

/* pce_input_top.sv */
/*
 * Joypad connector as the console reads it.
 * joy_in follows any input change within two clk_sys cycles.
 */

`timescale 1ns/1ps

module pce_input_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  pce_input_pkg::port_ctl_t  port_ctl,
	input  pce_input_pkg::input_cfg_t cfg,
	input  pce_input_pkg::pad_set_t   pads,
	input  pce_input_pkg::mouse_pkt_t mouse_pkt,
	output pce_input_pkg::nibble_t    joy_in
);

	import pce_input_pkg::*;

	scan_state_t scan;
	mouse_byte_t mouse_byte;

	multitap_scanner multitap_scanner_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.port_ctl (port_ctl),
		.cfg      (cfg),
		.scan     (scan)
	);

	// Select and Run of pad 0 pass through on the mouse port
	mouse_reader mouse_reader_i (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.port_ctl        (port_ctl),
		.pkt             (mouse_pkt),
		.pad0_select_run (pads[0][7:6]),
		.mouse_byte      (mouse_byte)
	);

	pad_nibble_select pad_nibble_select_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.port_ctl   (port_ctl),
		.cfg        (cfg),
		.pads       (pads),
		.scan       (scan),
		.mouse_byte (mouse_byte),
		.joy_in     (joy_in)
	);

endmodule

/* pad_nibble_select.sv */
/*
 * Builds the 16-bit word of the selected port and registers one nibble.
 * Ports past the last pad read F in the low three nibbles.
 */

`timescale 1ns/1ps

`include "pce_input_defs.svh"

module pad_nibble_select (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_input_pkg::port_ctl_t   port_ctl,
	input  pce_input_pkg::input_cfg_t  cfg,
	input  pce_input_pkg::pad_set_t    pads,
	input  pce_input_pkg::scan_state_t scan,
	input  pce_input_pkg::mouse_byte_t mouse_byte,
	output pce_input_pkg::nibble_t     joy_in
);

	import pce_input_pkg::*;

	logic [15:0] port_word;
	logic [3:0]  bit_base;

	// Connector order, active low, top nibble always 0
	function automatic logic [15:0] pad_word(input pad_buttons_t b);
		logic [3:0] dirs;
		dirs = {b[2], b[1], b[0], b[3]};
		return {4'h0, ~b[11:8], ~dirs, ~b[7:4]};
	endfunction

	always_comb begin
		port_word = 16'h0FFF;
		for (int i = 0; i < `PCE_PAD_COUNT; i++) begin
			if (scan.port == port_num_t'(i)) begin
				port_word = pad_word(pads[i]);
			end
		end
		// Mouse sits in place of pad 0
		if (scan.port == '0 && cfg.mouse_en) begin
			port_word = {mouse_byte, mouse_byte};
		end
	end

	// Nibble 0..3 picked by {high_bank, sel}
	assign bit_base = {scan.high_bank, port_ctl.sel, 2'b00};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_in <= '0;
		end else if (port_ctl.clr) begin
			joy_in <= '0;
		end else begin
			joy_in <= port_word[bit_base +: 4];
		end
	end

	// ========================================
	// Checks
	// ========================================

	joy_zero_after_clr: assert property (
		@(posedge clk_sys) disable iff (reset)
		port_ctl.clr |=> (joy_in == '0)
	);

endmodule

/* mouse_reader.sv */
/*
 * Mouse on port 0. Motion is read as four nibbles, one per clr pulse.
 * A new packet is seen when stb differs from its value one cycle earlier.
 * Left and right buttons are shown live, motion only after a full read.
 */

`timescale 1ns/1ps

`include "pce_input_defs.svh"

module mouse_reader (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_input_pkg::port_ctl_t   port_ctl,
	input  pce_input_pkg::mouse_pkt_t  pkt,
	input  logic [1:0]                 pad0_select_run,
	output pce_input_pkg::mouse_byte_t mouse_byte
);

	logic                            last_clr;
	logic                            last_stb;
	logic                            clr_rise;
	logic [`PCE_MOUSE_IDLE_BITS-1:0] idle_cnt;
	logic [1:0]                      nib_idx;

	// Pending motion from the host, latched motion seen by the console
	logic [7:0] pend_x;
	logic [7:0] pend_y;
	logic [7:0] ms_x;
	logic [7:0] ms_y;

	assign clr_rise = port_ctl.clr & ~last_clr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_clr <= 1'b0;
			last_stb <= 1'b0;
			idle_cnt <= '0;
			nib_idx  <= 2'd3;
			pend_x   <= '0;
			pend_y   <= '0;
			ms_x     <= '0;
			ms_y     <= '0;
		end else begin
			last_clr <= port_ctl.clr;
			last_stb <= pkt.stb;

			if (port_ctl.clr) begin
				idle_cnt <= '0;
			end else if (~&idle_cnt) begin
				idle_cnt <= idle_cnt + 1'b1;
			end

			// Console gave up mid-read, start over at x high
			if (&idle_cnt) begin
				nib_idx <= 2'd3;
			end

			if (clr_rise) begin
				nib_idx <= nib_idx + 1'b1;
				if (&nib_idx) begin
					ms_x   <= pend_x;
					ms_y   <= pend_y;
					pend_x <= '0;
					pend_y <= '0;
				end
			end

			// Host x axis runs the other way
			if (pkt.stb ^ last_stb) begin
				pend_x <= 8'd0 - pkt.dx;
				pend_y <= pkt.dy;
			end
		end
	end

	assign mouse_byte[3:0] = ~{pad0_select_run, pkt.flags[0], pkt.flags[1]};

	always_comb begin
		case (nib_idx)
			2'd0:    mouse_byte[7:4] = ms_x[7:4];
			2'd1:    mouse_byte[7:4] = ms_x[3:0];
			2'd2:    mouse_byte[7:4] = ms_y[7:4];
			default: mouse_byte[7:4] = ms_y[3:0];
		endcase
	end

endmodule

/* multitap_scanner.sv */
/*
 * Multitap port counter and six-button bank flag.
 * sel and clr are taken as already synchronous to clk_sys.
 */

`timescale 1ns/1ps

module multitap_scanner (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  pce_input_pkg::port_ctl_t   port_ctl,
	input  pce_input_pkg::input_cfg_t  cfg,
	output pce_input_pkg::scan_state_t scan
);

	import pce_input_pkg::*;

	logic last_sel;
	logic last_clr;
	logic sel_rise;
	logic clr_rise;

	assign sel_rise = port_ctl.sel & ~last_sel;
	assign clr_rise = port_ctl.clr & ~last_clr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_sel <= 1'b0;
			last_clr <= 1'b0;
			scan     <= '0;
		end else begin
			last_sel <= port_ctl.sel;
			last_clr <= port_ctl.clr;

			if (port_ctl.clr) begin
				scan.port <= '0;
				// Each clr pulse flips the bank on a six-button pad
				if (clr_rise) begin
					scan.high_bank <= ~scan.high_bank & cfg.six_button_en;
				end
			end else if (sel_rise && cfg.multitap_en) begin
				scan.port <= scan.port + port_num_t'(1);
			end
		end
	end

	// ========================================
	// Checks
	// ========================================

	// clr always returns the tap to the first pad
	port_zero_after_clr: assert property (
		@(posedge clk_sys) disable iff (reset)
		port_ctl.clr |=> (scan.port == '0)
	);

endmodule

/* pce_input_pkg.sv */
/*
 * Types shared by the input block and its testbench.
 * Pad buttons are active high here. The connector inverts them.
 */

`include "pce_input_defs.svh"

package pce_input_pkg;

	// One pad, bit 0 right .. bit 3 up, 4..7 I/II/Select/Run, 8..11 III..VI
	typedef logic [11:0] pad_buttons_t;

	// All multitap pads, pad 0 in the low bits
	typedef pad_buttons_t [`PCE_PAD_COUNT-1:0] pad_set_t;

	typedef logic [`PCE_PORT_BITS-1:0] port_num_t;
	typedef logic [`PCE_NIBBLE_BITS-1:0] nibble_t;
	typedef logic [7:0] mouse_byte_t;

	// Console control lines, sel in bit 0
	typedef struct packed {
		logic clr;
		logic sel;
	} port_ctl_t;

	// Static configuration levels
	typedef struct packed {
		logic multitap_en;
		logic six_button_en;
		logic mouse_en;
	} input_cfg_t;

	// Same layout as the host mouse word, stb toggles per packet
	typedef struct packed {
		logic       stb;
		logic [7:0] dy;
		logic [7:0] dx;
		logic [7:0] flags;
	} mouse_pkt_t;

	typedef struct packed {
		port_num_t port;
		logic      high_bank;
	} scan_state_t;

endpackage

/* pce_input_defs.svh */
/*
 * Joypad connector sizes for the console input block.
 * PCE_PAD_COUNT must stay below 2**PCE_PORT_BITS so that the spare ports read F.
 */

`ifndef PCE_INPUT_DEFS_SVH
`define PCE_INPUT_DEFS_SVH

// ========================================
// Multitap
// ========================================

// Pads behind the multitap
`define PCE_PAD_COUNT 5

// Port counter, wraps at 8
`define PCE_PORT_BITS 3

// ========================================
// Mouse and data bus
// ========================================

// Idle counter, about 1.3 ms at 25 MHz before the nibble index resets
`define PCE_MOUSE_IDLE_BITS 15

// Data nibble returned to the console
`define PCE_NIBBLE_BITS 4

`endif
